//--- design/phy_reset_pkg.sv
// transceiver reset sequencer types and delay defaults, shared by the sequencer and its checks
package phy_reset_pkg;

    // sequencer walks these in order, one reset stage released per state
    typedef enum logic [2:0]
    {
        ST_HOLD,        // everything held in reset
        ST_TX_CAL,      // tx analog released, waiting for tx calibration
        ST_TX_DIG,      // tx settling delay
        ST_RX_CAL,      // waiting for rx calibration
        ST_RX_LOCK,     // waiting for stable lock to data
        ST_RUN          // link up
    } reset_state_t;

    // settling delay counter
    typedef logic [15:0] delay_count_t;

    // board defaults at 50 MHz
    localparam delay_count_t DEF_TX_DIG_DELAY  = 16'd100;
    localparam delay_count_t DEF_RX_LOCK_DELAY = 16'd1000;

endpackage

//--- design/send_sched_pkg.sv
// send scheduler counter type and default period and window constants for the top level
package send_sched_pkg;

    // period counter and its compare points
    typedef logic [31:0] send_count_t;

    // ------------------------------------------------------------------------
    // board defaults at 50 MHz
    // ------------------------------------------------------------------------

    // channel 1 window opens about every two seconds
    localparam send_count_t DEF_PERIOD_1  = 32'd100_000_000;

    // channel 2 window lands later in the same period
    localparam send_count_t DEF_PERIOD_2  = 32'd117_000_000;

    // window length in counting cycles
    localparam send_count_t DEF_BURST_LEN = 32'd3;

    // idle gap after channel 2 before the counter wraps
    localparam send_count_t DEF_WRAP_GAP  = 32'd10;

endpackage

//--- design/send_phase_if.sv
// per-channel window strobes and qualifiers, driven by the period timer and read by one channel
`timescale 1ns/1ps

interface send_phase_if;

    logic run;          // link ready qualifier, registered
    logic host_send;    // registered host request
    logic burst_start;  // one-cycle pulse, window opens
    logic burst_end;    // one-cycle pulse, window closes

    // timer side drives everything
    modport timer (output run, output host_send, output burst_start, output burst_end);

    // channel side only listens
    modport channel (input run, input host_send, input burst_start, input burst_end);

endinterface

//--- design/phy_reset_seq.sv
// transceiver reset sequencer; releases tx then rx resets in order and reports tx_ready/rx_ready
`timescale 1ns/1ps

module phy_reset_seq #(
    parameter phy_reset_pkg::delay_count_t TX_DIG_DELAY  = phy_reset_pkg::DEF_TX_DIG_DELAY,
    parameter phy_reset_pkg::delay_count_t RX_LOCK_DELAY = phy_reset_pkg::DEF_RX_LOCK_DELAY
)
(
    input  logic clk_50_pll,
    input  logic main_reset,

    input  logic tx_cal_busy,
    input  logic rx_cal_busy,
    input  logic rx_locked_to_data,

    output logic tx_analogreset,
    output logic tx_digitalreset,
    output logic rx_analogreset,
    output logic rx_digitalreset,
    output logic tx_ready,
    output logic rx_ready
);

    // last count of each settling delay
    localparam phy_reset_pkg::delay_count_t TX_DIG_LAST  = TX_DIG_DELAY - 16'd1;
    localparam phy_reset_pkg::delay_count_t RX_LOCK_LAST = RX_LOCK_DELAY - 16'd1;

    phy_reset_pkg::reset_state_t state;
    phy_reset_pkg::delay_count_t delay_cnt;

    // ------------------------------------------------------------------------
    // sequencer, outputs registered so the transceiver never sees a glitch
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
        begin
            state           <= phy_reset_pkg::ST_HOLD;
            delay_cnt       <= '0;
            tx_analogreset  <= 1'b1;
            tx_digitalreset <= 1'b1;
            rx_analogreset  <= 1'b1;
            rx_digitalreset <= 1'b1;
            tx_ready        <= 1'b0;
            rx_ready        <= 1'b0;
        end
        else
        begin
            case (state)
                phy_reset_pkg::ST_HOLD:
                begin
                    tx_analogreset <= 1'b0;     // first edge after release
                    state          <= phy_reset_pkg::ST_TX_CAL;
                end
                phy_reset_pkg::ST_TX_CAL:
                begin
                    if (!tx_cal_busy)
                    begin
                        delay_cnt <= '0;
                        state     <= phy_reset_pkg::ST_TX_DIG;
                    end
                end
                phy_reset_pkg::ST_TX_DIG:
                begin
                    if (delay_cnt == TX_DIG_LAST)
                    begin
                        tx_digitalreset <= 1'b0;
                        tx_ready        <= 1'b1;
                        state           <= phy_reset_pkg::ST_RX_CAL;
                    end
                    else
                    begin
                        delay_cnt <= delay_cnt + 16'd1;
                    end
                end
                phy_reset_pkg::ST_RX_CAL:
                begin
                    if (!rx_cal_busy)
                    begin
                        rx_analogreset <= 1'b0;
                        delay_cnt      <= '0;
                        state          <= phy_reset_pkg::ST_RX_LOCK;
                    end
                end
                phy_reset_pkg::ST_RX_LOCK:
                begin
                    if (!rx_locked_to_data)
                        delay_cnt <= '0;        // lock must be consecutive
                    else if (delay_cnt == RX_LOCK_LAST)
                    begin
                        rx_digitalreset <= 1'b0;
                        rx_ready        <= 1'b1;
                        state           <= phy_reset_pkg::ST_RUN;
                    end
                    else
                        delay_cnt <= delay_cnt + 16'd1;
                end
                phy_reset_pkg::ST_RUN:
                begin
                    // lost lock, back to rx digital reset and count again
                    if (!rx_locked_to_data)
                    begin
                        rx_digitalreset <= 1'b1;
                        rx_ready        <= 1'b0;
                        delay_cnt       <= '0;
                        state           <= phy_reset_pkg::ST_RX_LOCK;
                    end
                end
                default:
                begin
                    state <= phy_reset_pkg::ST_HOLD;
                end
            endcase
        end
    end

endmodule

//--- design/send_period_timer.sv
// shared send period counter; decodes window strobes for both channels and wraps each period
`timescale 1ns/1ps

module send_period_timer #(
    parameter send_sched_pkg::send_count_t PERIOD_1  = send_sched_pkg::DEF_PERIOD_1,
    parameter send_sched_pkg::send_count_t PERIOD_2  = send_sched_pkg::DEF_PERIOD_2,
    parameter send_sched_pkg::send_count_t BURST_LEN = send_sched_pkg::DEF_BURST_LEN,
    parameter send_sched_pkg::send_count_t WRAP_GAP  = send_sched_pkg::DEF_WRAP_GAP
)
(
    input  logic        clk_50_pll,
    input  logic        main_reset,

    input  logic        mac_inited,
    input  logic        rx_ready,
    input  logic        host_send,

    send_phase_if.timer phase_1,
    send_phase_if.timer phase_2
);

    // compare points beyond the two window starts
    localparam send_sched_pkg::send_count_t END_1   = PERIOD_1 + BURST_LEN;
    localparam send_sched_pkg::send_count_t END_2   = PERIOD_2 + BURST_LEN;
    localparam send_sched_pkg::send_count_t WRAP_AT = PERIOD_2 + WRAP_GAP;

    logic                        run_q;
    logic                        host_q;
    logic                        counting;
    send_sched_pkg::send_count_t period_cnt;

    assign counting = run_q & host_q;

    // input qualifiers, one cycle behind the pins
    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
        begin
            run_q  <= 1'b0;
            host_q <= 1'b0;
        end
        else
        begin
            run_q  <= mac_inited & rx_ready;
            host_q <= host_send;
        end
    end

    // ------------------------------------------------------------------------
    // period counter and strobe decode
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
        begin
            period_cnt          <= '0;
            phase_1.burst_start <= 1'b0;
            phase_1.burst_end   <= 1'b0;
            phase_2.burst_start <= 1'b0;
            phase_2.burst_end   <= 1'b0;
        end
        else
        begin
            if (counting)
                period_cnt <= (period_cnt == WRAP_AT) ? '0 : period_cnt + 32'd1;

            // strobes only on a counting cycle, so each fires once per period
            phase_1.burst_start <= counting && (period_cnt == PERIOD_1);
            phase_1.burst_end   <= counting && (period_cnt == END_1);
            phase_2.burst_start <= counting && (period_cnt == PERIOD_2);
            phase_2.burst_end   <= counting && (period_cnt == END_2);
        end
    end

    assign phase_1.run       = run_q;
    assign phase_1.host_send = host_q;
    assign phase_2.run       = run_q;
    assign phase_2.host_send = host_q;

endmodule

//--- design/send_channel.sv
// send command generator for one channel; window strobes in, command level out, optional echo
`timescale 1ns/1ps

module send_channel #(
    parameter bit ECHO_EN = 1'b0    // resend while a received packet is stored
)
(
    input  logic          clk_50_pll,
    input  logic          main_reset,

    send_phase_if.channel phase,

    input  logic          data_saved,
    output logic          cmd_send
);

    logic echo_req;

    // echo only matters when the host is idle
    assign echo_req = ECHO_EN && data_saved;

    // ------------------------------------------------------------------------
    // command level, no acknowledge from the mac
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
        begin
            cmd_send <= 1'b0;
        end
        else if (phase.run)             // link down, hold whatever we had
        begin
            if (phase.host_send)
            begin
                if (phase.burst_start)
                    cmd_send <= 1'b1;
                else if (phase.burst_end)
                    cmd_send <= 1'b0;
            end
            else
            begin
                cmd_send <= echo_req;   // host idle
            end
        end
    end

endmodule

//--- design/heartbeat_divider.sv
// heartbeat for the health led; toggles every BLINK_DIVIDE clocks to show clock and reset alive
`timescale 1ns/1ps

module heartbeat_divider #(
    parameter int unsigned BLINK_DIVIDE = 25_000_000
)
(
    input  logic clk_50_pll,
    input  logic main_reset,
    output logic blink_led
);

    localparam int unsigned CNT_W = $clog2(BLINK_DIVIDE);
    localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(BLINK_DIVIDE - 1);

    logic [CNT_W-1:0] div_cnt;

    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
        begin
            div_cnt   <= '0;
            blink_led <= 1'b0;
        end
        else if (div_cnt == DIV_LAST)
        begin
            div_cnt   <= '0;
            blink_led <= ~blink_led;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

endmodule

//--- design/sfp_port_ctrl_top.sv
// board control top level for the sfp/sgmii test; phy reset order, send scheduling and leds
`timescale 1ns/1ps

module sfp_port_ctrl_top #(
    parameter send_sched_pkg::send_count_t PERIOD_1      = send_sched_pkg::DEF_PERIOD_1,
    parameter send_sched_pkg::send_count_t PERIOD_2      = send_sched_pkg::DEF_PERIOD_2,
    parameter send_sched_pkg::send_count_t BURST_LEN     = send_sched_pkg::DEF_BURST_LEN,
    parameter send_sched_pkg::send_count_t WRAP_GAP      = send_sched_pkg::DEF_WRAP_GAP,
    parameter phy_reset_pkg::delay_count_t TX_DIG_DELAY  = phy_reset_pkg::DEF_TX_DIG_DELAY,
    parameter phy_reset_pkg::delay_count_t RX_LOCK_DELAY = phy_reset_pkg::DEF_RX_LOCK_DELAY,
    parameter int unsigned                 BLINK_DIVIDE  = 25_000_000
)
(
    input  logic clk_50_pll,
    input  logic main_reset,

    input  logic mac_inited,
    input  logic host_send,         // host asks for periodic sends
    input  logic data_saved_2,      // channel 2 holds a received packet

    input  logic tx_cal_busy,
    input  logic rx_cal_busy,
    input  logic rx_locked_to_data,
    input  logic rx_locked_to_ref,

    output logic tx_analogreset,
    output logic tx_digitalreset,
    output logic rx_analogreset,
    output logic rx_digitalreset,
    output logic tx_ready,
    output logic rx_ready,

    output logic cmd_send_1,
    output logic cmd_send_2,

    output logic blink_led,
    output logic sfp_txflt_led,
    output logic sfp_rlos_led,
    output logic sfp_prsn_led
);

    send_phase_if phase_1 ();
    send_phase_if phase_2 ();

    // ------------------------------------------------------------------------
    // transceiver reset order
    // ------------------------------------------------------------------------
    phy_reset_seq #(
        .TX_DIG_DELAY       (TX_DIG_DELAY),
        .RX_LOCK_DELAY      (RX_LOCK_DELAY)
    ) phy_reset_seq_i (
        .clk_50_pll         (clk_50_pll),
        .main_reset         (main_reset),
        .tx_cal_busy        (tx_cal_busy),
        .rx_cal_busy        (rx_cal_busy),
        .rx_locked_to_data  (rx_locked_to_data),
        .tx_analogreset     (tx_analogreset),
        .tx_digitalreset    (tx_digitalreset),
        .rx_analogreset     (rx_analogreset),
        .rx_digitalreset    (rx_digitalreset),
        .tx_ready           (tx_ready),
        .rx_ready           (rx_ready)
    );

    // ------------------------------------------------------------------------
    // send scheduling, one shared timer and two channels
    // ------------------------------------------------------------------------
    send_period_timer #(
        .PERIOD_1   (PERIOD_1),
        .PERIOD_2   (PERIOD_2),
        .BURST_LEN  (BURST_LEN),
        .WRAP_GAP   (WRAP_GAP)
    ) send_period_timer_i (
        .clk_50_pll (clk_50_pll),
        .main_reset (main_reset),
        .mac_inited (mac_inited),
        .rx_ready   (rx_ready),
        .host_send  (host_send),
        .phase_1    (phase_1.timer),
        .phase_2    (phase_2.timer)
    );

    send_channel #(.ECHO_EN(1'b0)) send_channel_1_i (
        .clk_50_pll (clk_50_pll),
        .main_reset (main_reset),
        .phase      (phase_1.channel),
        .data_saved (1'b0),             // channel 1 has no echo path
        .cmd_send   (cmd_send_1)
    );

    send_channel #(.ECHO_EN(1'b1)) send_channel_2_i (
        .clk_50_pll (clk_50_pll),
        .main_reset (main_reset),
        .phase      (phase_2.channel),
        .data_saved (data_saved_2),
        .cmd_send   (cmd_send_2)
    );

    heartbeat_divider #(.BLINK_DIVIDE(BLINK_DIVIDE)) heartbeat_divider_i (
        .clk_50_pll (clk_50_pll),
        .main_reset (main_reset),
        .blink_led  (blink_led)
    );

    // status leds straight from the link state
    assign sfp_txflt_led = mac_inited;
    assign sfp_rlos_led  = rx_ready;
    assign sfp_prsn_led  = rx_locked_to_ref;

endmodule

//--- test/sfp_port_ctrl_props.sv
// bound checks on transceiver reset order and host-mode send window length
`timescale 1ns/1ps

module sfp_port_ctrl_props #(
    parameter int unsigned BURST_LEN = 3
)
(
    input logic clk_50_pll,
    input logic main_reset,
    input logic tx_analogreset,
    input logic tx_digitalreset,
    input logic rx_analogreset,
    input logic rx_digitalreset,
    input logic rx_ready,
    input logic run,
    input logic host_send,
    input logic burst_start,
    input logic cmd_send
);

    logic [15:0] count_hist;    // bit 0 is the last edge

    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
            count_hist <= '0;
        else
            count_hist <= {count_hist[14:0], run && host_send};
    end

    // ------------------------------------------------------------------------
    // reset order
    // ------------------------------------------------------------------------
    tx_order: assert property (@(posedge clk_50_pll) disable iff (main_reset)
        tx_analogreset |-> tx_digitalreset)
        else $error("tx digital reset released while tx analog reset is high");

    rx_ready_clean: assert property (@(posedge clk_50_pll) disable iff (main_reset)
        rx_ready |-> (!rx_analogreset && !rx_digitalreset))
        else $error("rx_ready high while an rx reset is still asserted");

    // window taken and counting never paused, so the level lasts BURST_LEN edges
    window_len: assert property (@(posedge clk_50_pll) disable iff (main_reset)
        ($past(run && host_send && burst_start, BURST_LEN)
            && (&count_hist[BURST_LEN-1:0]) && run && host_send)
        |=> (!cmd_send && $past(cmd_send) && $past(cmd_send, BURST_LEN)))
        else $error("host-mode send command did not last exactly the window length");

endmodule

bind phy_reset_seq sfp_port_ctrl_props #(.BURST_LEN(3)) reset_props_i (
    .clk_50_pll      (clk_50_pll),
    .main_reset      (main_reset),
    .tx_analogreset  (tx_analogreset),
    .tx_digitalreset (tx_digitalreset),
    .rx_analogreset  (rx_analogreset),
    .rx_digitalreset (rx_digitalreset),
    .rx_ready        (rx_ready),
    .run             (1'b0),
    .host_send       (1'b0),
    .burst_start     (1'b0),
    .cmd_send        (1'b0)
);

bind send_channel sfp_port_ctrl_props #(.BURST_LEN(3)) window_props_i (
    .clk_50_pll      (clk_50_pll),
    .main_reset      (main_reset),
    .tx_analogreset  (1'b0),
    .tx_digitalreset (1'b0),
    .rx_analogreset  (1'b0),
    .rx_digitalreset (1'b0),
    .rx_ready        (1'b0),
    .run             (phase.run),
    .host_send       (phase.host_send),
    .burst_start     (phase.burst_start),
    .cmd_send        (cmd_send)
);

//--- test/tb_sfp_port_ctrl_top.sv
// testbench for the sfp port control top; random stimulus checked every cycle against a model
`timescale 1ns/1ps

module tb_sfp_port_ctrl_top;

    localparam send_sched_pkg::send_count_t PERIOD_1      = 32'd20;
    localparam send_sched_pkg::send_count_t PERIOD_2      = 32'd40;
    localparam send_sched_pkg::send_count_t BURST_LEN     = 32'd3;
    localparam send_sched_pkg::send_count_t WRAP_GAP      = 32'd10;
    localparam phy_reset_pkg::delay_count_t TX_DIG_DELAY  = 16'd4;
    localparam phy_reset_pkg::delay_count_t RX_LOCK_DELAY = 16'd6;
    localparam int unsigned                 BLINK_DIVIDE  = 16;
    localparam int unsigned RAND_SEED      = 5047;
    localparam int unsigned TEST_CYCLES    = 6000;
    localparam int unsigned TIMEOUT_CYCLES = 20000;    // 5 reset and 6000 run cycles with wide margin

    logic clk_50_pll = 1'b0;
    logic main_reset, mac_inited, host_send, data_saved_2;
    logic tx_cal_busy, rx_cal_busy, rx_locked_to_data, rx_locked_to_ref;
    logic tx_analogreset, tx_digitalreset, rx_analogreset, rx_digitalreset;
    logic tx_ready, rx_ready, cmd_send_1, cmd_send_2;
    logic blink_led, sfp_txflt_led, sfp_rlos_led, sfp_prsn_led;

    // model state updated once per rising edge
    phy_reset_pkg::reset_state_t exp_state;
    phy_reset_pkg::delay_count_t tx_wait;       // edges left before tx digital release
    phy_reset_pkg::delay_count_t lock_run;      // consecutive locked samples
    send_sched_pkg::send_count_t exp_count;
    logic exp_tx_an, exp_tx_dig, exp_rx_an, exp_rx_dig, exp_tx_ready, exp_rx_ready;
    logic q_run, q_host, exp_start_1, exp_end_1, exp_start_2, exp_end_2;
    logic exp_cmd_1, exp_cmd_2, exp_blink;
    int unsigned div_ticks;

    int unsigned checks = 0, errors = 0, cycle_count = 0;
    int unsigned windows_1 = 0, windows_2 = 0, lock_losses = 0;
    int unsigned tx_busy_left, rx_busy_left, lock_off_left, mac_off_left, host_left;

    sfp_port_ctrl_top #(
        .PERIOD_1       (PERIOD_1),
        .PERIOD_2       (PERIOD_2),
        .BURST_LEN      (BURST_LEN),
        .WRAP_GAP       (WRAP_GAP),
        .TX_DIG_DELAY   (TX_DIG_DELAY),
        .RX_LOCK_DELAY  (RX_LOCK_DELAY),
        .BLINK_DIVIDE   (BLINK_DIVIDE)
    ) sfp_port_ctrl_top_i (.*);

    always #4 clk_50_pll = ~clk_50_pll;     // 8 ns period

    function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
        return lo + ($urandom % (hi - lo + 1));
    endfunction

    task automatic reset_model();
        exp_state    = phy_reset_pkg::ST_HOLD;
        tx_wait      = '0;
        lock_run     = '0;
        exp_count    = '0;
        {exp_tx_an, exp_tx_dig, exp_rx_an, exp_rx_dig} = 4'b1111;
        {exp_tx_ready, exp_rx_ready, q_run, q_host} = 4'b0000;
        {exp_start_1, exp_end_1, exp_start_2, exp_end_2} = 4'b0000;
        {exp_cmd_1, exp_cmd_2, exp_blink} = 3'b000;
        div_ticks    = 0;
    endtask

    // ------------------------------------------------------------------------
    // reset order rules
    // ------------------------------------------------------------------------
    task automatic step_sequencer();
        case (exp_state)
            phy_reset_pkg::ST_HOLD:
            begin
                exp_tx_an = 1'b0;
                exp_state = phy_reset_pkg::ST_TX_CAL;
            end
            phy_reset_pkg::ST_TX_CAL:
                if (!tx_cal_busy)
                begin
                    tx_wait   = TX_DIG_DELAY;
                    exp_state = phy_reset_pkg::ST_TX_DIG;
                end
            phy_reset_pkg::ST_TX_DIG:
            begin
                tx_wait = tx_wait - 16'd1;
                if (tx_wait == 16'd0)
                begin
                    exp_tx_dig   = 1'b0;
                    exp_tx_ready = 1'b1;
                    exp_state    = phy_reset_pkg::ST_RX_CAL;
                end
            end
            phy_reset_pkg::ST_RX_CAL:
                if (!rx_cal_busy)
                begin
                    exp_rx_an = 1'b0;
                    lock_run  = '0;
                    exp_state = phy_reset_pkg::ST_RX_LOCK;
                end
            phy_reset_pkg::ST_RX_LOCK:
            begin
                lock_run = rx_locked_to_data ? lock_run + 16'd1 : 16'd0;
                if (lock_run == RX_LOCK_DELAY)
                begin
                    exp_rx_dig   = 1'b0;
                    exp_rx_ready = 1'b1;
                    exp_state    = phy_reset_pkg::ST_RUN;
                end
            end
            default:
                if (!rx_locked_to_data)     // lock lost while running
                begin
                    exp_rx_dig   = 1'b1;
                    exp_rx_ready = 1'b0;
                    lock_run     = '0;
                    exp_state    = phy_reset_pkg::ST_RX_LOCK;
                    lock_losses++;
                end
        endcase
    endtask

    // ordered so every stage reads the values from before this edge
    task automatic step_model();
        logic counting;
        if (main_reset)
            reset_model();
        else
        begin
            counting = q_run && q_host;
            if (q_run && q_host)
            begin
                if (exp_start_1)
                    windows_1++;
                if (exp_start_2)
                    windows_2++;
                exp_cmd_1 = exp_start_1 ? 1'b1 : (exp_end_1 ? 1'b0 : exp_cmd_1);
                exp_cmd_2 = exp_start_2 ? 1'b1 : (exp_end_2 ? 1'b0 : exp_cmd_2);
            end
            else if (q_run)
            begin
                exp_cmd_1 = 1'b0;
                exp_cmd_2 = data_saved_2;   // echo of the stored packet
            end
            exp_start_1 = counting && (exp_count == PERIOD_1);
            exp_end_1   = counting && (exp_count == PERIOD_1 + BURST_LEN);
            exp_start_2 = counting && (exp_count == PERIOD_2);
            exp_end_2   = counting && (exp_count == PERIOD_2 + BURST_LEN);
            if (counting)
                exp_count = (exp_count == PERIOD_2 + WRAP_GAP) ? '0 : exp_count + 32'd1;
            q_run  = mac_inited && exp_rx_ready;
            q_host = host_send;
            step_sequencer();
            div_ticks++;
            if (div_ticks == BLINK_DIVIDE)
            begin
                div_ticks = 0;
                exp_blink = ~exp_blink;
            end
        end
    endtask

    task automatic compare_output(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0d ns: %s is %b, model expects %b", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        compare_output("tx_analogreset", tx_analogreset, exp_tx_an);
        compare_output("tx_digitalreset", tx_digitalreset, exp_tx_dig);
        compare_output("rx_analogreset", rx_analogreset, exp_rx_an);
        compare_output("rx_digitalreset", rx_digitalreset, exp_rx_dig);
        compare_output("tx_ready", tx_ready, exp_tx_ready);
        compare_output("rx_ready", rx_ready, exp_rx_ready);
        compare_output("cmd_send_1", cmd_send_1, exp_cmd_1);
        compare_output("cmd_send_2", cmd_send_2, exp_cmd_2);
        compare_output("blink_led", blink_led, exp_blink);
        compare_output("sfp_txflt_led", sfp_txflt_led, mac_inited);
        compare_output("sfp_rlos_led", sfp_rlos_led, exp_rx_ready);
        compare_output("sfp_prsn_led", sfp_prsn_led, rx_locked_to_ref);
    endtask

    task automatic drive_inputs();
        // calibration ends once and stays done
        if (tx_busy_left != 0)
            tx_busy_left--;
        if (rx_busy_left != 0)
            rx_busy_left--;
        tx_cal_busy = (tx_busy_left != 0);
        rx_cal_busy = (rx_busy_left != 0);
        if (lock_off_left != 0)
            lock_off_left--;
        else if ($urandom % 300 == 0)
            lock_off_left = rand_range(1, 10);      // short lock drop
        rx_locked_to_data = (lock_off_left == 0);
        if (mac_off_left != 0)
            mac_off_left--;
        else if ($urandom % 700 == 0)
            mac_off_left = rand_range(2, 20);
        mac_inited = (mac_off_left == 0);
        if (host_left != 0)
            host_left--;
        else
        begin
            host_send = ~host_send;
            host_left = host_send ? rand_range(60, 400) : rand_range(10, 120);
        end
        if ($urandom % 6 == 0)
            data_saved_2 = ~data_saved_2;
        if ($urandom % 20 == 0)
            rx_locked_to_ref = ~rx_locked_to_ref;
    endtask

    always @(posedge clk_50_pll)
        step_model();

    always @(negedge clk_50_pll)
        check_outputs();

    always @(posedge clk_50_pll)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial
    begin
        int unsigned seed_ret;
        seed_ret          = $urandom(RAND_SEED);
        main_reset        = 1'b1;
        mac_inited        = 1'b0;
        host_send         = 1'b0;
        data_saved_2      = 1'b0;
        tx_cal_busy       = 1'b1;
        rx_cal_busy       = 1'b1;
        rx_locked_to_data = 1'b0;
        rx_locked_to_ref  = 1'b0;
        tx_busy_left      = rand_range(5, 40);
        rx_busy_left      = rand_range(10, 80);
        lock_off_left     = rand_range(20, 60);
        mac_off_left      = rand_range(30, 90);
        host_left         = rand_range(20, 60);
        repeat (5) @(posedge clk_50_pll);
        #1;
        main_reset = 1'b0;
        repeat (TEST_CYCLES)
        begin
            @(posedge clk_50_pll);
            #1;
            drive_inputs();
        end
        @(negedge clk_50_pll);
        #1;     // last compare done
        if (windows_1 == 0 || windows_2 == 0 || lock_losses == 0)
            $display("stimulus never opened a send window on both channels or never lost lock");
        $display("summary: %0d checks, %0d errors, %0d + %0d windows, %0d lock losses",
                 checks, errors, windows_1, windows_2, lock_losses);
        if (errors == 0 && windows_1 != 0 && windows_2 != 0 && lock_losses != 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- sfp_port_ctrl_top.f
design/phy_reset_pkg.sv
design/send_sched_pkg.sv
design/send_phase_if.sv
design/phy_reset_seq.sv
design/send_period_timer.sv
design/send_channel.sv
design/heartbeat_divider.sv
design/sfp_port_ctrl_top.sv
test/sfp_port_ctrl_props.sv
test/tb_sfp_port_ctrl_top.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sfp_port_ctrl_top.f \
    --top-module tb_sfp_port_ctrl_top \
    -o tb_sfp_port_ctrl_top

status=0
./obj_dir/tb_sfp_port_ctrl_top > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
